// File: hw/tengbaser_macros.svh
`ifndef TENGBASER_MACROS_SVH
`define TENGBASER_MACROS_SVH

// reset sequencer intervals, in core_clk cycles

// qpllreset hold after reset release
`define TENGBASER_RST_HOLD_CYCLES 16

// wait for qplllock before restarting the hold
`define TENGBASER_LOCK_TIMEOUT 256

// gttxreset / gtrxreset pulse width
`define TENGBASER_GT_RST_CYCLES 8

// status counter widths, sized like the pcs status vector fields

// errored block count, status bits 279:272
`define TENGBASER_ERR_BLK_W 8

// ber count, status bits 285:280
`define TENGBASER_BER_W 6

// test pattern error count, status bits 303:288
`define TENGBASER_TPE_W 16

`endif

// File: hw/tengbaser_rst_pkg.sv
`default_nettype none

package tengbaser_rst_pkg;

  // bring-up order of the transceiver resets
  typedef enum logic [1:0] {
    RST_HOLD      = 2'd0,
    RST_WAIT_LOCK = 2'd1,
    RST_GT        = 2'd2,
    RST_DONE      = 2'd3
  } rst_state_e;

  // reset outputs toward qpll, gt and the core datapath
  typedef struct packed {
    logic qpllreset;
    logic gttxreset;
    logic gtrxreset;
    logic txuserrdy;
    logic reset_counter_done;
    logic areset_core;
  } gt_rst_t;

  // per-state output levels
  function automatic gt_rst_t decode_gt_rst(input rst_state_e state);
    gt_rst_t r;
    // everything held by default
    r.qpllreset          = 1'b1;
    r.gttxreset          = 1'b1;
    r.gtrxreset          = 1'b1;
    r.txuserrdy          = 1'b0;
    r.reset_counter_done = 1'b0;
    r.areset_core        = 1'b1;
    // qpll runs once the hold is over
    if (state != RST_HOLD) begin
      r.qpllreset = 1'b0;
    end
    // gt and datapath released together at the end
    if (state == RST_DONE) begin
      r.gttxreset          = 1'b0;
      r.gtrxreset          = 1'b0;
      r.txuserrdy          = 1'b1;
      r.reset_counter_done = 1'b1;
      r.areset_core        = 1'b0;
    end
    return r;
  endfunction

endpackage

`default_nettype wire

// File: hw/tengbaser_mgmt_pkg.sv
`default_nettype none

`include "tengbaser_macros.svh"

package tengbaser_mgmt_pkg;

  // raw pcs status from the receive path
  typedef struct packed {
    // levels
    logic block_lock;
    logic hiber;
    // one-cycle strobes, one count per high cycle
    logic err_block;
    logic ber_event;
    logic test_patt_err;
  } pcs_raw_t;

  // management clears, config vector bits 518 and 519
  typedef struct packed {
    logic clear_pcs_status2;
    logic clear_test_patt_err_count;
  } mgmt_ctrl_t;

  // management status as seen on the status vector
  typedef struct packed {
    // live levels, registered once
    logic rx_locked;
    logic hiber;
    logic link_status;
    // latched until clear_pcs_status2
    logic rx_locked_ll;
    logic hiber_lh;
    // saturating event counts
    logic [`TENGBASER_ERR_BLK_W-1:0] err_block_count;
    logic [`TENGBASER_BER_W-1:0]     ber_count;
    logic [`TENGBASER_TPE_W-1:0]     test_patt_err_count;
  } pcs_status_t;

endpackage

`default_nettype wire

// File: hw/tengbaser_reset_seq.sv
`default_nettype none

`include "tengbaser_macros.svh"

module tengbaser_reset_seq (
  input  logic                      core_clk,
  input  logic                      rst,
  input  logic                      qplllock,
  output tengbaser_rst_pkg::gt_rst_t gt_rst
);

  import tengbaser_rst_pkg::*;

  // one counter serves hold, timeout and gt pulse
  // sized for the longest interval
  localparam int cnt_w = $clog2(`TENGBASER_LOCK_TIMEOUT);

  // load values, counter runs down to zero
  localparam logic [cnt_w-1:0] hold_load = cnt_w'(`TENGBASER_RST_HOLD_CYCLES - 1);
  localparam logic [cnt_w-1:0] timeout_load = cnt_w'(`TENGBASER_LOCK_TIMEOUT - 1);
  localparam logic [cnt_w-1:0] gt_load = cnt_w'(`TENGBASER_GT_RST_CYCLES - 1);

  rst_state_e state;
  rst_state_e state_next;

  logic [cnt_w-1:0] cnt;
  logic [cnt_w-1:0] cnt_next;
  logic             cnt_zero;

  // last cycle of the current interval
  assign cnt_zero = (cnt == '0);

  always_comb begin
    state_next = state;
    cnt_next   = cnt;
    case (state)
      // qpll held in reset for the hold interval
      RST_HOLD: begin
        if (cnt_zero) begin
          state_next = RST_WAIT_LOCK;
          cnt_next   = timeout_load;
        end else begin
          cnt_next = cnt - 1'b1;
        end
      end

      // first cycle with lock moves on
      RST_WAIT_LOCK: begin
        if (qplllock) begin
          state_next = RST_GT;
          cnt_next   = gt_load;
        end else if (cnt_zero) begin
          // no lock in time, start over with a fresh qpll reset
          state_next = RST_HOLD;
          cnt_next   = hold_load;
        end else begin
          cnt_next = cnt - 1'b1;
        end
      end

      // gt resets pulse while lock holds
      RST_GT: begin
        if (!qplllock) begin
          state_next = RST_HOLD;
          cnt_next   = hold_load;
        end else if (cnt_zero) begin
          state_next = RST_DONE;
        end else begin
          cnt_next = cnt - 1'b1;
        end
      end

      // running, watch for lock loss
      RST_DONE: begin
        if (!qplllock) begin
          state_next = RST_HOLD;
          cnt_next   = hold_load;
        end
      end

      default: begin
        state_next = RST_HOLD;
        cnt_next   = hold_load;
      end
    endcase
  end

  // outputs come from the next state so they line up with the state register
  // and leave a flop, no decode glitches on the reset lines
  always_ff @(posedge core_clk) begin
    if (rst) begin
      state  <= RST_HOLD;
      cnt    <= hold_load;
      gt_rst <= decode_gt_rst(RST_HOLD);
    end else begin
      state  <= state_next;
      cnt    <= cnt_next;
      gt_rst <= decode_gt_rst(state_next);
    end
  end

endmodule

`default_nettype wire

// File: hw/tengbaser_status_latch.sv
`default_nettype none

`include "tengbaser_macros.svh"

module tengbaser_status_latch (
  input  logic                            core_clk,
  input  logic                            rst,
  input  logic                            areset_core,
  input  tengbaser_mgmt_pkg::pcs_raw_t    pcs_raw,
  input  tengbaser_mgmt_pkg::mgmt_ctrl_t  mgmt_ctrl,
  output tengbaser_mgmt_pkg::pcs_status_t pcs_status
);

  localparam int err_w = `TENGBASER_ERR_BLK_W;
  localparam int ber_w = `TENGBASER_BER_W;
  localparam int tpe_w = `TENGBASER_TPE_W;

  // saturation points
  localparam logic [tpe_w-1:0] err_top = {{(tpe_w - err_w){1'b0}}, {err_w{1'b1}}};
  localparam logic [tpe_w-1:0] ber_top = {{(tpe_w - ber_w){1'b0}}, {ber_w{1'b1}}};
  localparam logic [tpe_w-1:0] tpe_top = {tpe_w{1'b1}};

  // datapath held until the transceivers are up
  logic dp_rst;

  assign dp_rst = rst | areset_core;

  // next count, evaluated at the widest width
  // clear beats a same-cycle event, stop at top
  function automatic logic [tpe_w-1:0] sat_next(
    input logic [tpe_w-1:0] cur,
    input logic [tpe_w-1:0] top,
    input logic             ev,
    input logic             clr
  );
    if (clr) begin
      return '0;
    end
    if (ev && (cur != top)) begin
      return cur + 1'b1;
    end
    return cur;
  endfunction

  always_ff @(posedge core_clk) begin
    if (dp_rst) begin
      pcs_status.rx_locked           <= 1'b0;
      pcs_status.hiber               <= 1'b1;
      pcs_status.link_status         <= 1'b0;
      pcs_status.rx_locked_ll        <= 1'b0;
      pcs_status.hiber_lh            <= 1'b1;
      pcs_status.err_block_count     <= '0;
      pcs_status.ber_count           <= '0;
      pcs_status.test_patt_err_count <= '0;
    end else begin
      // live levels
      pcs_status.rx_locked   <= pcs_raw.block_lock;
      pcs_status.hiber       <= pcs_raw.hiber;
      pcs_status.link_status <= pcs_raw.block_lock & ~pcs_raw.hiber;

      // latched low, rises only when a clear reloads it
      if (mgmt_ctrl.clear_pcs_status2) begin
        pcs_status.rx_locked_ll <= pcs_raw.block_lock;
      end else if (!pcs_raw.block_lock) begin
        pcs_status.rx_locked_ll <= 1'b0;
      end

      // latched high, mirror image
      if (mgmt_ctrl.clear_pcs_status2) begin
        pcs_status.hiber_lh <= pcs_raw.hiber;
      end else if (pcs_raw.hiber) begin
        pcs_status.hiber_lh <= 1'b1;
      end

      // errored blocks and ber share the status2 clear
      pcs_status.err_block_count <= err_w'(sat_next(
        pcs_status.err_block_count, err_top,
        pcs_raw.err_block, mgmt_ctrl.clear_pcs_status2));
      pcs_status.ber_count <= ber_w'(sat_next(
        pcs_status.ber_count, ber_top,
        pcs_raw.ber_event, mgmt_ctrl.clear_pcs_status2));

      // test pattern errors have their own clear
      pcs_status.test_patt_err_count <= sat_next(
        pcs_status.test_patt_err_count, tpe_top,
        pcs_raw.test_patt_err, mgmt_ctrl.clear_test_patt_err_count);
    end
  end

endmodule

`default_nettype wire

// File: hw/tengbaser_infrastructure.sv
`default_nettype none

module tengbaser_infrastructure (
  // 156.25 MHz core clock
  input  logic                            core_clk,
  input  logic                            rst,
  // qpll lock from the common block
  input  logic                            qplllock,
  // raw pcs status and management clears
  input  tengbaser_mgmt_pkg::pcs_raw_t    pcs_raw,
  input  tengbaser_mgmt_pkg::mgmt_ctrl_t  mgmt_ctrl,
  // transceiver and datapath resets
  output tengbaser_rst_pkg::gt_rst_t      gt_rst,
  // latched management status
  output tengbaser_mgmt_pkg::pcs_status_t pcs_status
);

  // qpll / gt reset bring-up
  tengbaser_reset_seq reset_seq_i (
    .core_clk (core_clk),
    .rst      (rst),
    .qplllock (qplllock),
    .gt_rst   (gt_rst)
  );

  // status latching, held in reset until the datapath is released
  // also cleared again on any lock loss through areset_core
  tengbaser_status_latch status_latch_i (
    .core_clk    (core_clk),
    .rst         (rst),
    .areset_core (gt_rst.areset_core),
    .pcs_raw     (pcs_raw),
    .mgmt_ctrl   (mgmt_ctrl),
    .pcs_status  (pcs_status)
  );

endmodule

`default_nettype wire

// File: tb/tengbaser_infrastructure_checker.sv
`default_nettype none

module tengbaser_infrastructure_checker (
  input logic                       core_clk,
  input logic                       rst,
  input logic                       qplllock,
  input tengbaser_rst_pkg::gt_rst_t gt_rst
);

  // failed assertions, read by the testbench at the end of the run
  int assert_fails = 0;

  // user ready only ever follows a cycle with qpll lock
  ready_after_lock: assert property (
    @(posedge core_clk) disable iff (rst)
    gt_rst.txuserrdy |-> $past(qplllock)
  ) else begin
    assert_fails++;
    $error("txuserrdy high without qplllock in the previous cycle");
  end

  // gt reset and user ready are exclusive
  gt_reset_vs_ready: assert property (
    @(posedge core_clk) disable iff (rst)
    !(gt_rst.gttxreset && gt_rst.txuserrdy)
  ) else begin
    assert_fails++;
    $error("gttxreset and txuserrdy high together");
  end

  // qpll held straight out of reset
  qpll_reset_after_rst: assert property (
    @(posedge core_clk) rst |=> gt_rst.qpllreset
  ) else begin
    assert_fails++;
    $error("qpllreset low in the cycle after rst");
  end

endmodule

bind tengbaser_reset_seq tengbaser_infrastructure_checker checker_i (
  .core_clk (core_clk),
  .rst      (rst),
  .qplllock (qplllock),
  .gt_rst   (gt_rst)
);

`default_nettype wire

// File: tb/tengbaser_infrastructure_tb.sv
`default_nettype none

`include "tengbaser_macros.svh"

module tengbaser_infrastructure_tb;

  import tengbaser_rst_pkg::*;
  import tengbaser_mgmt_pkg::*;

  // counter saturation points
  localparam int err_top = (1 << `TENGBASER_ERR_BLK_W) - 1;
  localparam int ber_top = (1 << `TENGBASER_BER_W) - 1;
  localparam int tpe_top = (1 << `TENGBASER_TPE_W) - 1;

  logic        core_clk;
  logic        rst;
  logic        qplllock;
  pcs_raw_t    pcs_raw;
  mgmt_ctrl_t  mgmt_ctrl;
  gt_rst_t     gt_rst;
  pcs_status_t pcs_status;

  // expected status, one register stage like the dut
  logic exp_rx_locked;
  logic exp_hiber;
  logic exp_link;
  logic exp_ll;
  logic exp_lh;
  int   exp_err;
  int   exp_ber;
  int   exp_tpe;

  // datapath reset as the latch sees it, tracked by the stimulus
  logic dp_rst_ref;
  logic clk_seen = 1'b0;

  int          err_count;
  int          timeout_count;
  string       test_name;
  logic [31:0] lcg_state;

  tengbaser_infrastructure uut (
    .core_clk   (core_clk),
    .rst        (rst),
    .qplllock   (qplllock),
    .pcs_raw    (pcs_raw),
    .mgmt_ctrl  (mgmt_ctrl),
    .gt_rst     (gt_rst),
    .pcs_status (pcs_status)
  );

  initial core_clk = 1'b0;
  always #50 core_clk = ~core_clk;

  function automatic int hold_cycles();
    return `TENGBASER_RST_HOLD_CYCLES;
  endfunction

  // one cycle to see lock, then the gt pulse
  function automatic int ready_cycles();
    return 1 + `TENGBASER_GT_RST_CYCLES;
  endfunction

  function automatic int timeout_cycles();
    return `TENGBASER_LOCK_TIMEOUT;
  endfunction

  // clear first, then count up to the top and stay there
  function automatic int expected_count(input int cur, input int top, input logic ev,
                                        input logic clr);
    if (clr) begin
      return 0;
    end
    if (ev && (cur < top)) begin
      return cur + 1;
    end
    return cur;
  endfunction

  function automatic logic latch_low_next(input logic cur, input logic lvl, input logic clr);
    return clr ? lvl : (cur & lvl);
  endfunction

  function automatic logic latch_high_next(input logic cur, input logic lvl, input logic clr);
    return clr ? lvl : (cur | lvl);
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic probe(input string sig);
    case (sig)
      "qpllreset": return gt_rst.qpllreset;
      "txuserrdy": return gt_rst.txuserrdy;
      default:     return 1'bx;
    endcase
  endfunction

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      err_count++;
    end
  endtask

  // falling edges until sig reaches level, bounded by limit
  task automatic count_until(input string sig, input logic level, input int limit,
                             output int n);
    n = 0;
    do begin
      @(negedge core_clk);
      n++;
    end while ((probe(sig) !== level) && (n < limit));
    if (probe(sig) !== level) begin
      $display("%s: %s did not reach %0b within %0d cycles", test_name, sig, level, limit);
      timeout_count++;
    end
  endtask

  task automatic check_all_resets(input string when);
    check_val({"qpllreset ", when}, 1, gt_rst.qpllreset);
    check_val({"gttxreset ", when}, 1, gt_rst.gttxreset);
    check_val({"gtrxreset ", when}, 1, gt_rst.gtrxreset);
    check_val({"txuserrdy ", when}, 0, gt_rst.txuserrdy);
    check_val({"reset_counter_done ", when}, 0, gt_rst.reset_counter_done);
    check_val({"areset_core ", when}, 1, gt_rst.areset_core);
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    dp_rst_ref = 1'b1;
    repeat (4) @(negedge core_clk);
    rst = 1'b0;
  endtask

  // hold, lock, gt pulse, then release with lock already present
  task automatic bring_up(input int hold_exp);
    int n;
    count_until("qpllreset", 1'b0, hold_exp + 8, n);
    check_val("qpllreset hold cycles", hold_exp, n);
    check_val("gttxreset after qpll release", 1, gt_rst.gttxreset);
    check_val("gtrxreset after qpll release", 1, gt_rst.gtrxreset);
    check_val("areset_core after qpll release", 1, gt_rst.areset_core);
    count_until("txuserrdy", 1'b1, ready_cycles() + 8, n);
    check_val("txuserrdy cycles", ready_cycles(), n);
    check_val("reset_counter_done with txuserrdy", 1, gt_rst.reset_counter_done);
    check_val("gttxreset with txuserrdy", 0, gt_rst.gttxreset);
    check_val("gtrxreset with txuserrdy", 0, gt_rst.gtrxreset);
    check_val("areset_core with txuserrdy", 0, gt_rst.areset_core);
    // latch leaves reset at the next rising edge
    dp_rst_ref = 1'b0;
  endtask

  // status model, inputs are stable at the rising edge
  always @(posedge core_clk) begin
    clk_seen <= 1'b1;
    if (rst || dp_rst_ref) begin
      exp_rx_locked <= 1'b0;
      exp_hiber     <= 1'b1;
      exp_link      <= 1'b0;
      exp_ll        <= 1'b0;
      exp_lh        <= 1'b1;
      exp_err       <= 0;
      exp_ber       <= 0;
      exp_tpe       <= 0;
    end else begin
      exp_rx_locked <= pcs_raw.block_lock;
      exp_hiber     <= pcs_raw.hiber;
      exp_link      <= pcs_raw.block_lock && !pcs_raw.hiber;
      exp_ll <= latch_low_next(exp_ll, pcs_raw.block_lock, mgmt_ctrl.clear_pcs_status2);
      exp_lh <= latch_high_next(exp_lh, pcs_raw.hiber, mgmt_ctrl.clear_pcs_status2);
      exp_err <= expected_count(exp_err, err_top, pcs_raw.err_block,
                                mgmt_ctrl.clear_pcs_status2);
      exp_ber <= expected_count(exp_ber, ber_top, pcs_raw.ber_event,
                                mgmt_ctrl.clear_pcs_status2);
      exp_tpe <= expected_count(exp_tpe, tpe_top, pcs_raw.test_patt_err,
                                mgmt_ctrl.clear_test_patt_err_count);
    end
  end

  // compare every status field mid-cycle
  always @(negedge core_clk) begin
    if (clk_seen) begin
      check_val("rx_locked", exp_rx_locked, pcs_status.rx_locked);
      check_val("hiber", exp_hiber, pcs_status.hiber);
      check_val("link_status", exp_link, pcs_status.link_status);
      check_val("rx_locked_ll", exp_ll, pcs_status.rx_locked_ll);
      check_val("hiber_lh", exp_lh, pcs_status.hiber_lh);
      check_val("err_block_count", exp_err, pcs_status.err_block_count);
      check_val("ber_count", exp_ber, pcs_status.ber_count);
      check_val("test_patt_err_count", exp_tpe, pcs_status.test_patt_err_count);
    end
  end

  initial begin
    int          n;
    int          n_err;
    int          n_ber;
    int          n_tpe;
    int          tpe_before;
    logic [31:0] r;
    rst           = 1'b1;
    qplllock      = 1'b1;
    pcs_raw       = '0;
    mgmt_ctrl     = '0;
    dp_rst_ref    = 1'b1;
    err_count     = 0;
    timeout_count = 0;
    lcg_state     = 32'hd0eeb0c5;
    pcs_raw.block_lock = 1'b1;

    // lock present from the start
    test_name = "bringup_locked";
    apply_reset();
    check_all_resets("at reset release");
    bring_up(hold_cycles());

    // no lock, qpll reset comes back after the timeout
    test_name = "lock_timeout";
    qplllock = 1'b0;
    apply_reset();
    count_until("qpllreset", 1'b0, hold_cycles() + 8, n);
    check_val("qpllreset hold cycles", hold_cycles(), n);
    count_until("qpllreset", 1'b1, timeout_cycles() + 8, n);
    check_val("lock timeout cycles", timeout_cycles(), n);
    check_val("txuserrdy without lock", 0, gt_rst.txuserrdy);
    check_val("areset_core without lock", 1, gt_rst.areset_core);
    qplllock = 1'b1;
    bring_up(hold_cycles());

    // random strobes, ber pulses often enough to saturate
    test_name = "random_events";
    n_err = 0;
    n_ber = 0;
    n_tpe = 0;
    repeat (300) begin
      @(negedge core_clk);
      lcg_state = lcg_next(lcg_state);
      r = lcg_state;
      pcs_raw.err_block     = r[31];
      pcs_raw.ber_event     = r[30];
      pcs_raw.test_patt_err = r[29] & r[28];
      n_err += r[31];
      n_ber += r[30];
      n_tpe += r[29] & r[28];
    end
    @(negedge core_clk);
    pcs_raw.err_block     = 1'b0;
    pcs_raw.ber_event     = 1'b0;
    pcs_raw.test_patt_err = 1'b0;
    check_val("err_block total", (n_err > err_top) ? err_top : n_err,
              pcs_status.err_block_count);
    check_val("ber total", (n_ber > ber_top) ? ber_top : n_ber, pcs_status.ber_count);
    check_val("test_patt_err total", (n_tpe > tpe_top) ? tpe_top : n_tpe,
              pcs_status.test_patt_err_count);
    if (n_ber <= ber_top) begin
      $display("random_events: too few ber pulses to reach saturation");
      err_count++;
    end

    // status2 clear with same-cycle events
    test_name = "clears";
    tpe_before = pcs_status.test_patt_err_count;
    mgmt_ctrl.clear_pcs_status2 = 1'b1;
    pcs_raw.err_block = 1'b1;
    pcs_raw.ber_event = 1'b1;
    @(negedge core_clk);
    mgmt_ctrl.clear_pcs_status2 = 1'b0;
    pcs_raw.err_block = 1'b0;
    pcs_raw.ber_event = 1'b0;
    check_val("err_block after status2 clear", 0, pcs_status.err_block_count);
    check_val("ber after status2 clear", 0, pcs_status.ber_count);
    check_val("test_patt_err kept", tpe_before, pcs_status.test_patt_err_count);
    // the reverse clear
    mgmt_ctrl.clear_test_patt_err_count = 1'b1;
    pcs_raw.test_patt_err = 1'b1;
    pcs_raw.err_block = 1'b1;
    pcs_raw.ber_event = 1'b1;
    @(negedge core_clk);
    mgmt_ctrl.clear_test_patt_err_count = 1'b0;
    pcs_raw.test_patt_err = 1'b0;
    pcs_raw.err_block = 1'b0;
    pcs_raw.ber_event = 1'b0;
    check_val("test_patt_err after its clear", 0, pcs_status.test_patt_err_count);
    check_val("err_block counted", 1, pcs_status.err_block_count);
    check_val("ber counted", 1, pcs_status.ber_count);

    // latched bits, reloaded by the status2 clear above
    test_name = "latched_bits";
    check_val("rx_locked_ll after clear", 1, pcs_status.rx_locked_ll);
    check_val("hiber_lh after clear", 0, pcs_status.hiber_lh);
    pcs_raw.block_lock = 1'b0;
    @(negedge core_clk);
    pcs_raw.block_lock = 1'b1;
    check_val("rx_locked_ll on drop", 0, pcs_status.rx_locked_ll);
    check_val("link_status on drop", 0, pcs_status.link_status);
    repeat (3) @(negedge core_clk);
    check_val("rx_locked_ll held", 0, pcs_status.rx_locked_ll);
    check_val("link_status back", 1, pcs_status.link_status);
    pcs_raw.hiber = 1'b1;
    @(negedge core_clk);
    pcs_raw.hiber = 1'b0;
    check_val("hiber_lh on pulse", 1, pcs_status.hiber_lh);
    check_val("link_status in hiber", 0, pcs_status.link_status);
    repeat (3) @(negedge core_clk);
    check_val("hiber_lh held", 1, pcs_status.hiber_lh);
    check_val("link_status after hiber", 1, pcs_status.link_status);
    mgmt_ctrl.clear_pcs_status2 = 1'b1;
    @(negedge core_clk);
    mgmt_ctrl.clear_pcs_status2 = 1'b0;
    check_val("rx_locked_ll reloaded", 1, pcs_status.rx_locked_ll);
    check_val("hiber_lh reloaded", 0, pcs_status.hiber_lh);

    // lock loss while running, counters filled first
    test_name = "lock_loss";
    pcs_raw.err_block     = 1'b1;
    pcs_raw.ber_event     = 1'b1;
    pcs_raw.test_patt_err = 1'b1;
    repeat (5) @(negedge core_clk);
    pcs_raw.err_block     = 1'b0;
    pcs_raw.ber_event     = 1'b0;
    pcs_raw.test_patt_err = 1'b0;
    qplllock = 1'b0;
    @(negedge core_clk);
    check_all_resets("after lock loss");
    dp_rst_ref = 1'b1;
    qplllock = 1'b1;
    @(negedge core_clk);
    check_val("err_block after lock loss", 0, pcs_status.err_block_count);
    check_val("ber after lock loss", 0, pcs_status.ber_count);
    check_val("test_patt_err after lock loss", 0, pcs_status.test_patt_err_count);
    // one hold cycle already spent above
    bring_up(hold_cycles() - 1);

    @(negedge core_clk);
    $display("checks done: %0d value errors, %0d timeouts, %0d assertion failures",
             err_count, timeout_count, uut.reset_seq_i.checker_i.assert_fails);
    if ((err_count == 0) && (timeout_count == 0) &&
        (uut.reset_seq_i.checker_i.assert_fails == 0)) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/tengbaser_rst_pkg.sv
hw/tengbaser_mgmt_pkg.sv
hw/tengbaser_reset_seq.sv
hw/tengbaser_status_latch.sv
hw/tengbaser_infrastructure.sv
tb/tengbaser_infrastructure_checker.sv
tb/tengbaser_infrastructure_tb.sv

// File: Bender.yml
package:
  name: tengbaser_infrastructure

sources:
  - include_dirs:
      - hw
    files:
      - hw/tengbaser_rst_pkg.sv
      - hw/tengbaser_mgmt_pkg.sv
      - hw/tengbaser_reset_seq.sv
      - hw/tengbaser_status_latch.sv
      - hw/tengbaser_infrastructure.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/tengbaser_infrastructure_checker.sv
      - tb/tengbaser_infrastructure_tb.sv
